// File: project.f
src/radio_pkg.sv
src/radio_regs_pkg.sv
src/sid_demux.sv
src/stream_fifo.sv
src/ctrl_proc_fsm.sv
src/timekeeper.sv
src/settings_bank.sv
src/radio_core.sv
sim/radio_props.sv
sim/tb_radio.sv

// File: run_sim.sh
#!/bin/sh
# Build the radio testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_radio -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_radio > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
   exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
   echo "Simulation log holds no final verdict"
   exit 1
fi
exit 0

// File: sim/tb_radio.sv
`timescale 1ns/1ps

module tb_radio
   import radio_pkg::*, radio_regs_pkg::*;
();

   localparam int          CLK_PERIOD      = 100;
   localparam logic [31:0] RADIO_NUM       = 32'h0000_0003;
   localparam logic [31:0] MISC_IN         = 32'hc0de_5a5a;
   localparam logic [63:0] TIME_LOAD       = 64'h0000_0123_4567_89ab;
   localparam int          NUM_ROWS        = 10;
   localparam int          ROW_CYCLES      = 80;
   localparam int          NUM_TX_PKTS     = 8;
   localparam int          TX_CYCLES       = 600;
   localparam int          WATCHDOG_CYCLES = NUM_ROWS * ROW_CYCLES + TX_CYCLES + 200;
   localparam int          WAIT_LIMIT      = 200;

   // How the expected readback of a row is found
   localparam logic [1:0] KIND_FIXED = 2'd0;
   localparam logic [1:0] KIND_MISC  = 2'd1;
   localparam logic [1:0] KIND_TIME  = 2'd2;

   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] data;
      rb_sel_e     sel;
      logic [1:0]  kind;
      logic        pps;
      logic [63:0] exp_rb;
   } row_t;

   logic         bus_clk;
   logic         bus_rst;
   stream_beat_t i_in_beat;
   logic         i_in_valid;
   logic         o_in_ready;
   stream_beat_t o_tx_beat;
   logic         o_tx_valid;
   logic         i_tx_ready;
   stream_beat_t o_resp_beat;
   logic         o_resp_valid;
   logic         i_resp_ready;
   logic [31:0]  i_misc_ins;
   logic [31:0]  o_misc_outs;
   logic         i_pps;
   logic         o_sync_dacs;

   integer       seed = 32'hf5dcb159;
   int           err_count;
   int           tests_passed;
   int           tests_failed;
   int           sync_count;
   logic [11:0]  seq_next;
   row_t         rows [NUM_ROWS];
   logic [63:0]  fill [NUM_TX_PKTS * 4];
   stream_beat_t resp_q [$];
   stream_beat_t tx_got [$];
   stream_beat_t tx_exp [$];

   radio_core #(
      .RADIO_NUM(RADIO_NUM),
      .DATA_FIFO_SIZE(2),
      .MSG_FIFO_SIZE(3)
   ) u_radio_core (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .i_in_beat(i_in_beat), .i_in_valid(i_in_valid), .o_in_ready(o_in_ready),
      .o_tx_beat(o_tx_beat), .o_tx_valid(o_tx_valid), .i_tx_ready(i_tx_ready),
      .o_resp_beat(o_resp_beat), .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready),
      .i_misc_ins(i_misc_ins), .o_misc_outs(o_misc_outs),
      .i_pps(i_pps), .o_sync_dacs(o_sync_dacs));

   initial begin
      bus_clk = 1'b0;
      forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
   end

   // Random back-pressure on both outputs
   // transmit stalls about one cycle in four, responses one in two
   initial begin
      logic [31:0] rnd;
      i_tx_ready   = 1'b0;
      i_resp_ready = 1'b0;
      forever begin
         @(negedge bus_clk);
         rnd          = $random(seed);
         i_tx_ready   = ((rnd & 32'h3) != 32'h0);
         i_resp_ready = ((rnd & 32'h10) != 32'h0);
      end
   end

   ////////////////////////////////////////////////////
   // Output monitors
   always @(posedge bus_clk) begin
      if (o_resp_valid && i_resp_ready) begin
         resp_q.push_back(o_resp_beat);
      end
      if (o_tx_valid && i_tx_ready) begin
         tx_got.push_back(o_tx_beat);
      end
      if (o_sync_dacs) begin
         sync_count++;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

   function automatic logic [63:0] make_hdr(input logic [11:0] seq, input logic [15:0] len,
                                            input logic [31:0] sid);
      return {4'h0, seq, len, sid};
   endfunction

   // Sequence number echoed, stream ID halves exchanged, all else zero
   function automatic logic [63:0] expected_resp_hdr(input logic [11:0] seq,
                                                     input logic [31:0] sid);
      return {4'h0, seq, 16'h0000, sid[15:0], sid[31:16]};
   endfunction

   task automatic load_table();
      rows[0] = '{SR_TEST, 32'hdead_beef, RB_TEST, KIND_FIXED, 1'b0, 64'h0000_0000_dead_beef};
      rows[1] = '{SR_TEST, 32'h1234_5678, RB_TEST, KIND_FIXED, 1'b0, 64'h0000_0000_1234_5678};
      rows[2] = '{SR_MISC_OUTS, 32'h0f0f_a5a5, RB_MISC, KIND_MISC, 1'b0, 64'h0};
      rows[3] = '{SR_DACSYNC, 32'h0, RB_RADIO_NUM, KIND_FIXED, 1'b0, {32'h0, RADIO_NUM}};
      rows[4] = '{SR_TIME_HI, TIME_LOAD[63:32], RB_TEST, KIND_FIXED, 1'b0, 64'h1234_5678};
      rows[5] = '{SR_TIME_LO, TIME_LOAD[31:0], RB_TEST, KIND_FIXED, 1'b0, 64'h1234_5678};
      // Arm the load for the next pps edge
      rows[6] = '{SR_TIME_CTRL, 32'h0000_0002, RB_TEST, KIND_FIXED, 1'b0, 64'h1234_5678};
      rows[7] = '{SR_TEST, 32'h0000_0042, RB_LASTPPS, KIND_FIXED, 1'b1, TIME_LOAD};
      rows[8] = '{SR_DACSYNC, 32'h0000_0001, RB_TIME, KIND_TIME, 1'b0, 64'h0};
      rows[9] = '{SR_MISC_OUTS, 32'h8000_0001, RB_MISC, KIND_MISC, 1'b0, 64'h0};
   endtask

   task automatic send_beat(input stream_beat_t beat);
      int waited;
      waited     = 0;
      i_in_beat  = beat;
      i_in_valid = 1'b1;
      @(posedge bus_clk);
      while (!o_in_ready && waited < WAIT_LIMIT) begin
         waited++;
         @(posedge bus_clk);
      end
      if (!o_in_ready) begin
         $display("Input beat %h was not accepted within %0d cycles", beat.data, WAIT_LIMIT);
         err_count++;
      end
      @(negedge bus_clk);
      i_in_valid = 1'b0;
   endtask

   task automatic ctrl_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [63:0] rb, output logic got);
      logic [11:0]  seq;
      logic [31:0]  sid;
      stream_beat_t beat;
      stream_beat_t resp_hdr;
      stream_beat_t resp_data;
      int           waited;
      seq       = seq_next;
      seq_next  = seq_next + 12'd1;
      sid       = {4'ha, seq, 16'h5a01};
      beat.last = 1'b0;
      beat.data = make_hdr(seq, 16'd16, sid);
      send_beat(beat);
      beat.last = 1'b1;
      beat.data = {24'h0, addr, data};
      send_beat(beat);
      waited = 0;
      while (resp_q.size() < 2 && waited < WAIT_LIMIT) begin
         @(negedge bus_clk);
         waited++;
      end
      rb  = '0;
      got = 1'b0;
      if (resp_q.size() < 2) begin
         $display("No response to control write of %h at address %h", data, addr);
         err_count++;
         resp_q.delete();
      end else begin
         resp_hdr  = resp_q.pop_front();
         resp_data = resp_q.pop_front();
         if (resp_hdr.data !== expected_resp_hdr(seq, sid)) begin
            $display("FAIL o_resp_beat.data (header) got %h expected %h",
                     resp_hdr.data, expected_resp_hdr(seq, sid));
            err_count++;
         end
         if ({resp_hdr.last, resp_data.last} !== 2'b01) begin
            $display("FAIL o_resp_beat.last got %h expected %h",
                     {resp_hdr.last, resp_data.last}, 2'b01);
            err_count++;
         end
         rb  = resp_data.data;
         got = 1'b1;
      end
   endtask

   task automatic pulse_pps();
      i_pps = 1'b1;
      repeat (4) @(negedge bus_clk);
      i_pps = 1'b0;
      repeat (4) @(negedge bus_clk);
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (err_count == errs_before) begin
         tests_passed++;
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, err_count - errs_before);
      end
   endtask

   ////////////////////////////////////////////////////
   // Setting table, one row per test
   task automatic apply_row(input int r);
      row_t        row;
      logic [63:0] rb;
      logic [63:0] exp_rb;
      logic        got;
      int          errs_before;
      int          sync_before;
      int          exp_pulses;
      row         = rows[r];
      errs_before = err_count;
      sync_before = sync_count;
      if (row.pps) begin
         pulse_pps();
      end
      ctrl_write(SR_READBACK, {29'h0, row.sel}, rb, got);
      ctrl_write(row.addr, row.data, rb, got);
      repeat (3) @(negedge bus_clk);
      if (got && row.kind == KIND_TIME) begin
         // Counter only runs forward from the loaded value
         if (rb < TIME_LOAD || rb >= TIME_LOAD + 64'(WATCHDOG_CYCLES)) begin
            $display("FAIL o_resp_beat.data got %h expected %h to %h", rb, TIME_LOAD,
                     TIME_LOAD + 64'(WATCHDOG_CYCLES) - 64'd1);
            err_count++;
         end
      end else if (got) begin
         exp_rb = (row.kind == KIND_MISC) ? {MISC_IN, row.data} : row.exp_rb;
         if (rb !== exp_rb) begin
            $display("FAIL o_resp_beat.data got %h expected %h", rb, exp_rb);
            err_count++;
         end
      end
      exp_pulses = (row.addr == SR_DACSYNC) ? 1 : 0;
      if (sync_count - sync_before != exp_pulses) begin
         $display("FAIL o_sync_dacs pulses got %h expected %h",
                  sync_count - sync_before, exp_pulses);
         err_count++;
      end
      if (row.addr == SR_MISC_OUTS && o_misc_outs !== row.data) begin
         $display("FAIL o_misc_outs got %h expected %h", o_misc_outs, row.data);
         err_count++;
      end
      finish_test($sformatf("row %0d address %h", r, row.addr), errs_before);
   endtask

   task automatic check_tx_stream();
      stream_beat_t beat;
      int           errs_before;
      int           waited;
      int           n;
      int           p;
      int           b;
      errs_before = err_count;
      tx_exp.delete();
      tx_got.delete();
      for (p = 0; p < NUM_TX_PKTS; p++) begin
         n         = p % 4 + 1;
         beat.last = 1'b0;
         beat.data = make_hdr(12'(p), 16'(8 * (n + 1)), 32'h3000_2200);
         tx_exp.push_back(beat);
         send_beat(beat);
         for (b = 0; b < n; b++) begin
            beat.last = (b == n - 1);
            beat.data = fill[p * 4 + b];
            tx_exp.push_back(beat);
            send_beat(beat);
         end
         // Channel 2 or 3 packet in between, dropped by the demux
         beat.last = 1'b0;
         beat.data = make_hdr(12'(p), 16'd16, 32'h3000_2202 | 32'(p % 2));
         send_beat(beat);
         beat.last = 1'b1;
         beat.data = {32'hdead_0000, 32'(p)};
         send_beat(beat);
      end
      waited = 0;
      while (tx_got.size() < tx_exp.size() && waited < TX_CYCLES) begin
         @(negedge bus_clk);
         waited++;
      end
      repeat (10) @(negedge bus_clk);
      if (tx_got.size() != tx_exp.size()) begin
         $display("Transmit output carried %0d beats where %0d were sent",
                  tx_got.size(), tx_exp.size());
         err_count++;
      end
      n = (tx_got.size() < tx_exp.size()) ? tx_got.size() : tx_exp.size();
      for (b = 0; b < n; b++) begin
         if (tx_got[b] !== tx_exp[b]) begin
            $display("FAIL o_tx_beat beat %0d got %h expected %h", b, tx_got[b], tx_exp[b]);
            err_count++;
         end
      end
      if (resp_q.size() != 0) begin
         $display("Data packets produced %0d beats on the response output", resp_q.size());
         err_count++;
         resp_q.delete();
      end
      finish_test("transmit stream", errs_before);
   endtask

   task automatic check_header_only();
      stream_beat_t beat;
      logic [63:0]  rb;
      logic         got;
      int           errs_before;
      errs_before = err_count;
      beat.last   = 1'b1;
      beat.data   = make_hdr(seq_next, 16'd8, 32'h7000_0101);
      seq_next    = seq_next + 12'd1;
      send_beat(beat);
      repeat (20) @(negedge bus_clk);
      if (resp_q.size() != 0) begin
         $display("A header-only control packet was answered with %0d beats", resp_q.size());
         err_count++;
         resp_q.delete();
      end
      ctrl_write(SR_READBACK, {29'h0, RB_TEST}, rb, got);
      ctrl_write(SR_TEST, 32'h0bad_f00d, rb, got);
      if (got && rb !== 64'h0000_0000_0bad_f00d) begin
         $display("FAIL o_resp_beat.data got %h expected %h", rb, 64'h0000_0000_0bad_f00d);
         err_count++;
      end
      finish_test("header-only control packet", errs_before);
   endtask

   ////////////////////////////////////////////////////
   // Main sequence
   initial begin
      int i;
      int r;
      bus_rst      = 1'b1;
      i_in_beat    = '0;
      i_in_valid   = 1'b0;
      i_misc_ins   = MISC_IN;
      i_pps        = 1'b0;
      err_count    = 0;
      tests_passed = 0;
      tests_failed = 0;
      sync_count   = 0;
      seq_next     = 12'h100;
      load_table();
      for (i = 0; i < NUM_TX_PKTS * 4; i++) begin
         fill[i] = {$random(seed), $random(seed)};
      end
      repeat (16) @(negedge bus_clk);
      bus_rst = 1'b0;
      repeat (2) @(negedge bus_clk);

      for (r = 0; r < NUM_ROWS; r++) begin
         apply_row(r);
      end
      check_tx_stream();
      check_header_only();

      if (u_radio_core.u_radio_props.fail_count != 0) begin
         $display("Bound assertions failed %0d times", u_radio_core.u_radio_props.fail_count);
         err_count++;
      end

      $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && err_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: sim/radio_props.sv
`timescale 1ns/1ps

module radio_props import radio_pkg::*; (
   input logic         bus_clk,
   input logic         bus_rst,
   input stream_beat_t o_resp_beat,
   input logic         o_resp_valid,
   input logic         i_resp_ready,
   input stream_beat_t o_tx_beat,
   input logic         o_tx_valid,
   input logic         i_tx_ready,
   input logic         o_sync_dacs,
   input logic [31:0]  o_misc_outs
);

   // Number of assertion failures so far
   int fail_count = 0;

   // A stalled beat waits unchanged until it is taken
   a_resp_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
      o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp_beat))
      else begin
         $error("o_resp beat dropped or changed while stalled");
         fail_count++;
      end

   a_tx_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
      o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_beat))
      else begin
         $error("o_tx beat dropped or changed while stalled");
         fail_count++;
      end

   a_sync_width: assert property (@(posedge bus_clk) disable iff (bus_rst)
      o_sync_dacs |=> !o_sync_dacs)
      else begin
         $error("o_sync_dacs pulse longer than one cycle");
         fail_count++;
      end

   a_reset_quiet: assert property (@(posedge bus_clk)
      bus_rst |=> !o_resp_valid && !o_tx_valid && !o_sync_dacs && (o_misc_outs == '0))
      else begin
         $error("Outputs active during reset");
         fail_count++;
      end

endmodule

bind radio_core radio_props u_radio_props (
   .bus_clk(bus_clk), .bus_rst(bus_rst),
   .o_resp_beat(o_resp_beat), .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready),
   .o_tx_beat(o_tx_beat), .o_tx_valid(o_tx_valid), .i_tx_ready(i_tx_ready),
   .o_sync_dacs(o_sync_dacs), .o_misc_outs(o_misc_outs));

// File: src/radio_core.sv
`timescale 1ns/1ps

module radio_core import radio_pkg::*; #(
   parameter logic [31:0] RADIO_NUM      = 32'd0,
   parameter int          DATA_FIFO_SIZE = 5,
   parameter int          MSG_FIFO_SIZE  = 3
) (
   input  logic         bus_clk,
   input  logic         bus_rst,
   input  stream_beat_t i_in_beat,
   input  logic         i_in_valid,
   output logic         o_in_ready,
   output stream_beat_t o_tx_beat,
   output logic         o_tx_valid,
   input  logic         i_tx_ready,
   output stream_beat_t o_resp_beat,
   output logic         o_resp_valid,
   input  logic         i_resp_ready,
   input  logic [31:0]  i_misc_ins,
   output logic [31:0]  o_misc_outs,
   input  logic         i_pps,
   output logic         o_sync_dacs
);

   stream_beat_t      dmx_tx_beat, dmx_ctrl_beat, ctrl_beat;
   logic              dmx_tx_valid, dmx_tx_ready;
   logic              dmx_ctrl_valid, dmx_ctrl_ready;
   logic              ctrl_valid, ctrl_ready;
   set_bus_t          set_bus;
   logic [TIME_W-1:0] cur_time, lastpps_time;
   logic [63:0]       readback;

   ////////////////////////////////////////////////////
   // Stream path
   sid_demux u_sid_demux (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .i_beat(i_in_beat), .i_valid(i_in_valid), .o_ready(o_in_ready),
      .o_tx_beat(dmx_tx_beat), .o_tx_valid(dmx_tx_valid), .i_tx_ready(dmx_tx_ready),
      .o_ctrl_beat(dmx_ctrl_beat), .o_ctrl_valid(dmx_ctrl_valid),
      .i_ctrl_ready(dmx_ctrl_ready));

   stream_fifo #(.DEPTH_LOG2(DATA_FIFO_SIZE)) u_tx_fifo (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .i_beat(dmx_tx_beat), .i_valid(dmx_tx_valid), .o_ready(dmx_tx_ready),
      .o_beat(o_tx_beat), .o_valid(o_tx_valid), .i_ready(i_tx_ready));

   stream_fifo #(.DEPTH_LOG2(MSG_FIFO_SIZE)) u_ctrl_fifo (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .i_beat(dmx_ctrl_beat), .i_valid(dmx_ctrl_valid), .o_ready(dmx_ctrl_ready),
      .o_beat(ctrl_beat), .o_valid(ctrl_valid), .i_ready(ctrl_ready));

   ////////////////////////////////////////////////////
   // Control and settings
   ctrl_proc_fsm u_ctrl_proc_fsm (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .i_beat(ctrl_beat), .i_valid(ctrl_valid), .o_ready(ctrl_ready),
      .o_set(set_bus), .i_readback(readback),
      .o_resp_beat(o_resp_beat), .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready));

   timekeeper u_timekeeper (
      .bus_clk(bus_clk), .bus_rst(bus_rst), .i_set(set_bus), .i_pps(i_pps),
      .o_time(cur_time), .o_time_lastpps(lastpps_time));

   settings_bank #(.RADIO_NUM(RADIO_NUM)) u_settings_bank (
      .bus_clk(bus_clk), .bus_rst(bus_rst), .i_set(set_bus),
      .i_time(cur_time), .i_time_lastpps(lastpps_time),
      .i_misc_ins(i_misc_ins), .o_misc_outs(o_misc_outs),
      .o_sync_dacs(o_sync_dacs), .o_readback(readback));

endmodule

// File: src/settings_bank.sv
`timescale 1ns/1ps

module settings_bank import radio_pkg::*, radio_regs_pkg::*; #(
   parameter logic [31:0] RADIO_NUM = 32'd0
) (
   input  logic              bus_clk,
   input  logic              bus_rst,
   input  set_bus_t          i_set,
   input  logic [TIME_W-1:0] i_time,
   input  logic [TIME_W-1:0] i_time_lastpps,
   input  logic [31:0]       i_misc_ins,
   output logic [31:0]       o_misc_outs,
   output logic              o_sync_dacs,
   output logic [63:0]       o_readback
);

   logic [31:0] test_q;
   logic [31:0] misc_q;
   rb_sel_e     rb_sel_q;
   logic        dac_hit_q;
   logic        sync_q;
   logic [63:0] rb_q;

   function automatic logic hit(input set_bus_t bus, input logic [7:0] addr);
      return bus.stb && (bus.addr == addr);
   endfunction

   ////////////////////////////////////////////////////
   // Setting registers
   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         test_q    <= '0;
         misc_q    <= '0;
         rb_sel_q  <= RB_TEST;
         dac_hit_q <= 1'b0;
         sync_q    <= 1'b0;
      end else begin
         if (hit(i_set, SR_TEST)) begin
            test_q <= i_set.data;
         end
         if (hit(i_set, SR_MISC_OUTS)) begin
            misc_q <= i_set.data;
         end
         if (hit(i_set, SR_READBACK)) begin
            rb_sel_q <= rb_sel_e'(i_set.data[2:0]);
         end
         // Any value written to the DAC sync address fires one pulse
         dac_hit_q <= hit(i_set, SR_DACSYNC);
         sync_q    <= dac_hit_q;
      end
   end

   ////////////////////////////////////////////////////
   // Registered readback mux
   always_ff @(posedge bus_clk) begin
      case (rb_sel_q)
         RB_TEST:      rb_q <= {32'h0, test_q};
         RB_TIME:      rb_q <= i_time;
         RB_LASTPPS:   rb_q <= i_time_lastpps;
         RB_MISC:      rb_q <= {i_misc_ins, misc_q};
         RB_RADIO_NUM: rb_q <= {32'h0, RADIO_NUM};
         default:      rb_q <= '0;
      endcase
   end

   assign o_misc_outs = misc_q;
   assign o_sync_dacs = sync_q;
   assign o_readback  = rb_q;

endmodule

// File: src/timekeeper.sv
`timescale 1ns/1ps

module timekeeper import radio_pkg::*, radio_regs_pkg::*; (
   input  logic              bus_clk,
   input  logic              bus_rst,
   input  set_bus_t          i_set,
   input  logic              i_pps,
   output logic [TIME_W-1:0] o_time,
   output logic [TIME_W-1:0] o_time_lastpps
);

   logic [TIME_W-1:0] time_q;
   logic [TIME_W-1:0] lastpps_q;
   logic [TIME_W-1:0] pending_q;
   logic              pps_q;
   logic              armed_q;
   logic              pps_edge;
   logic              ctrl_wr;

   assign pps_edge = i_pps && !pps_q;
   assign ctrl_wr  = i_set.stb && (i_set.addr == SR_TIME_CTRL);

   // Pending load value, written in two halves
   always_ff @(posedge bus_clk) begin
      if (i_set.stb && (i_set.addr == SR_TIME_HI)) begin
         pending_q[63:32] <= i_set.data;
      end
      if (i_set.stb && (i_set.addr == SR_TIME_LO)) begin
         pending_q[31:0] <= i_set.data;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         time_q    <= '0;
         lastpps_q <= '0;
         pps_q     <= 1'b0;
         armed_q   <= 1'b0;
      end else begin
         pps_q <= i_pps;
         if (ctrl_wr && i_set.data[TIME_CTRL_NOW_BIT]) begin
            time_q <= pending_q;
         end else if (pps_edge && armed_q) begin
            time_q <= pending_q;
         end else begin
            time_q <= time_q + 1'b1;
         end
         // An armed load is its own pps timestamp
         if (pps_edge) begin
            lastpps_q <= armed_q ? pending_q : time_q;
            armed_q   <= 1'b0;
         end
         if (ctrl_wr && i_set.data[TIME_CTRL_PPS_BIT]) begin
            armed_q <= 1'b1;
         end
      end
   end

   assign o_time         = time_q;
   assign o_time_lastpps = lastpps_q;

endmodule

// File: src/ctrl_proc_fsm.sv
`timescale 1ns/1ps

module ctrl_proc_fsm import radio_pkg::*; (
   input  logic         bus_clk,
   input  logic         bus_rst,
   input  stream_beat_t i_beat,
   input  logic         i_valid,
   output logic         o_ready,
   output set_bus_t     o_set,
   input  logic [63:0]  i_readback,
   output stream_beat_t o_resp_beat,
   output logic         o_resp_valid,
   input  logic         i_resp_ready
);

   typedef enum logic [2:0] {
      ST_HDR,
      ST_SET,
      ST_DRAIN,
      ST_WRITE,
      ST_RESP_HDR,
      ST_RESP_DATA
   } state_e;

   state_e      state_q;
   cvita_hdr_t  in_hdr;
   cvita_hdr_t  resp_hdr;
   logic [11:0] seq_q;
   logic [31:0] sid_q;
   logic [63:0] rb_q;
   logic        set_stb_q;
   logic [7:0]  set_addr_q;
   logic [31:0] set_data_q;
   logic        settle_q;
   logic        in_fire;
   logic        resp_fire;

   assign in_hdr       = i_beat.data;
   assign o_ready      = state_q inside {ST_HDR, ST_SET, ST_DRAIN};
   assign in_fire      = i_valid && o_ready;
   assign o_resp_valid = state_q inside {ST_RESP_HDR, ST_RESP_DATA};
   assign resp_fire    = o_resp_valid && i_resp_ready;

   always_comb begin
      o_set.stb  = set_stb_q;
      o_set.addr = set_addr_q;
      o_set.data = set_data_q;
   end

   // Response header echoes the sequence number, stream ID halves swapped
   always_comb begin
      resp_hdr        = '0;
      resp_hdr.seqnum = seq_q;
      resp_hdr.sid    = {sid_q[15:0], sid_q[31:16]};
   end

   always_comb begin
      if (state_q == ST_RESP_DATA) begin
         o_resp_beat.last = 1'b1;
         o_resp_beat.data = rb_q;
      end else begin
         o_resp_beat.last = 1'b0;
         o_resp_beat.data = resp_hdr;
      end
   end

   ////////////////////////////////////////////////////
   // Packet state machine
   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         state_q   <= ST_HDR;
         set_stb_q <= 1'b0;
         settle_q  <= 1'b0;
      end else begin
         set_stb_q <= (state_q == ST_SET) && in_fire;
         case (state_q)
            ST_HDR: begin
               // A header that is also last carries no setting
               if (in_fire && !i_beat.last) begin
                  state_q <= ST_SET;
               end
            end
            ST_SET: begin
               if (in_fire) begin
                  state_q <= i_beat.last ? ST_WRITE : ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               if (in_fire && i_beat.last) begin
                  state_q <= ST_WRITE;
               end
            end
            ST_WRITE: begin
               // Two cycles so the registered readback sees the new value
               settle_q <= !settle_q;
               if (settle_q) begin
                  state_q <= ST_RESP_HDR;
               end
            end
            ST_RESP_HDR: begin
               if (resp_fire) begin
                  state_q <= ST_RESP_DATA;
               end
            end
            ST_RESP_DATA: begin
               if (resp_fire) begin
                  state_q <= ST_HDR;
               end
            end
            default: state_q <= ST_HDR;
         endcase
      end
   end

   always_ff @(posedge bus_clk) begin
      if ((state_q == ST_HDR) && in_fire) begin
         seq_q <= in_hdr.seqnum;
         sid_q <= in_hdr.sid;
      end
      if ((state_q == ST_SET) && in_fire) begin
         set_addr_q <= i_beat.data[39:32];
         set_data_q <= i_beat.data[31:0];
      end
      // Readback is frozen so the data beat holds under back-pressure
      if ((state_q == ST_RESP_HDR) && resp_fire) begin
         rb_q <= i_readback;
      end
   end

endmodule

// File: src/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo import radio_pkg::*; #(
   parameter int DEPTH_LOG2 = 3
) (
   input  logic         bus_clk,
   input  logic         bus_rst,
   input  stream_beat_t i_beat,
   input  logic         i_valid,
   output logic         o_ready,
   output stream_beat_t o_beat,
   output logic         o_valid,
   input  logic         i_ready
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   stream_beat_t          mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  full;
   logic                  push;
   logic                  pop;

   assign full    = (count == (DEPTH_LOG2 + 1)'(DEPTH));
   assign o_valid = (count != '0);

   // A full buffer still takes a beat when one leaves in the same cycle
   assign o_ready = !full || i_ready;
   assign push    = i_valid && o_ready;
   assign pop     = o_valid && i_ready;
   assign o_beat  = mem[rd_ptr];

   ////////////////////////////////////////////////////
   // Pointers and occupancy
   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge bus_clk) begin
      if (push) begin
         mem[wr_ptr] <= i_beat;
      end
   end

endmodule

// File: src/sid_demux.sv
`timescale 1ns/1ps

module sid_demux import radio_pkg::*; (
   input  logic         bus_clk,
   input  logic         bus_rst,
   input  stream_beat_t i_beat,
   input  logic         i_valid,
   output logic         o_ready,
   output stream_beat_t o_tx_beat,
   output logic         o_tx_valid,
   input  logic         i_tx_ready,
   output stream_beat_t o_ctrl_beat,
   output logic         o_ctrl_valid,
   input  logic         i_ctrl_ready
);

   logic         first_q;
   sid_chan_e    chan_q;
   sid_chan_e    in_chan;
   sid_chan_e    out_chan;
   stream_beat_t out_beat;
   logic         out_valid;
   logic         out_ready;
   cvita_hdr_t   hdr;

   assign hdr = i_beat.data;

   // Route on the header beat, then keep the same port until last
   assign in_chan = first_q ? sid_chan_e'(hdr.sid[1:0]) : chan_q;

   // Unused channels drain at once
   always_comb begin
      case (out_chan)
         CHAN_TX_DATA: out_ready = i_tx_ready;
         CHAN_CTRL:    out_ready = i_ctrl_ready;
         default:      out_ready = 1'b1;
      endcase
   end

   assign o_ready = !out_valid || out_ready;

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         first_q   <= 1'b1;
         chan_q    <= CHAN_TX_DATA;
         out_chan  <= CHAN_TX_DATA;
         out_valid <= 1'b0;
      end else begin
         if (i_valid && o_ready) begin
            first_q <= i_beat.last;
            chan_q  <= in_chan;
         end
         if (o_ready) begin
            out_valid <= i_valid;
            out_chan  <= in_chan;
         end
      end
   end

   always_ff @(posedge bus_clk) begin
      if (i_valid && o_ready) begin
         out_beat <= i_beat;
      end
   end

   assign o_tx_beat    = out_beat;
   assign o_ctrl_beat  = out_beat;
   assign o_tx_valid   = out_valid && (out_chan == CHAN_TX_DATA);
   assign o_ctrl_valid = out_valid && (out_chan == CHAN_CTRL);

endmodule

// File: src/radio_regs_pkg.sv
package radio_regs_pkg;

   // Setting register map
   localparam logic [7:0] SR_DACSYNC   = 8'd5;
   localparam logic [7:0] SR_TEST      = 8'd7;
   localparam logic [7:0] SR_MISC_OUTS = 8'd24;
   localparam logic [7:0] SR_READBACK  = 8'd32;
   localparam logic [7:0] SR_TIME_HI   = 8'd128;
   localparam logic [7:0] SR_TIME_LO   = 8'd129;
   localparam logic [7:0] SR_TIME_CTRL = 8'd130;

   // Readback word selection
   typedef enum logic [2:0] {
      RB_TEST      = 3'd0,
      RB_TIME      = 3'd1,
      RB_LASTPPS   = 3'd2,
      RB_MISC      = 3'd3,
      RB_RADIO_NUM = 3'd4
   } rb_sel_e;

   // Bits of the time control register
   localparam int TIME_CTRL_NOW_BIT = 0;
   localparam int TIME_CTRL_PPS_BIT = 1;

endpackage

// File: src/radio_pkg.sv
package radio_pkg;

   // Width of the timekeeper counter
   localparam int TIME_W = 64;

   // One beat of the 64-bit packet stream
   typedef struct packed {
      logic        last;
      logic [63:0] data;
   } stream_beat_t;

   // Field view of a packet header beat
   typedef struct packed {
      logic [3:0]  pkt_type;
      logic [11:0] seqnum;
      logic [15:0] length;
      logic [31:0] sid;
   } cvita_hdr_t;

   // Destination taken from the two low stream ID bits
   typedef enum logic [1:0] {
      CHAN_TX_DATA = 2'd0,
      CHAN_CTRL    = 2'd1,
      CHAN_RX_FC   = 2'd2,
      CHAN_RX_CMD  = 2'd3
   } sid_chan_e;

   // Settings bus, one write per strobe
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

endpackage
